// File: axi_pkg.sv
// AXI4 write-channel widths and codes; WRAP and RESERVED decode but are walked as INCR
package axi_pkg;

    // ----------------------------------------------------------------------
    // Field widths of the AW and B channels
    // ----------------------------------------------------------------------

    // AWLEN holds beats minus one
    localparam int LEN_W   = 8;
    // AWSIZE is log2 of the bytes per beat
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // ----------------------------------------------------------------------
    // Burst types and response codes
    // ----------------------------------------------------------------------

    // Encodings follow the AXI4 AWBURST field
    typedef enum logic [BURST_W-1:0] {
        FIXED    = 2'b00,
        INCR     = 2'b01,
        WRAP     = 2'b10,
        RESERVED = 2'b11
    } burst_t;

    // Only OKAY and SLVERR are ever returned
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;

endpackage

// File: axi_slv_wr.sv
// AXI4 write slave, single clock, in-order responses, OKAY/SLVERR only, no WRAP
`timescale 1ns/1ps

module axi_slv_wr import axi_pkg::*; #(
    parameter int DATA_W   = 32,
    parameter int ADDR_W   = 32,
    parameter int ID_W     = 4,
    parameter int AW_DEPTH = 4,
    parameter int W_DEPTH  = 16,
    parameter int B_DEPTH  = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    // AW channel
    input  logic [ID_W-1:0]     aw_id,
    input  logic [ADDR_W-1:0]   aw_addr,
    input  logic [LEN_W-1:0]    aw_len,
    input  logic [SIZE_W-1:0]   aw_size,
    input  logic [BURST_W-1:0]  aw_burst,
    input  logic                aw_valid,
    output logic                aw_ready,
    // W channel
    input  logic [DATA_W-1:0]   w_data,
    input  logic [DATA_W/8-1:0] w_strb,
    input  logic                w_last,
    input  logic                w_valid,
    output logic                w_ready,
    // B channel
    output logic [ID_W-1:0]     b_id,
    output logic [RESP_W-1:0]   b_resp,
    output logic                b_valid,
    input  logic                b_ready,
    // User side
    input  logic                grant,
    output logic [ID_W-1:0]     m_id,
    output logic [LEN_W-1:0]    m_len,
    output logic [SIZE_W-1:0]   m_size,
    output logic [BURST_W-1:0]  m_burst,
    output logic [ADDR_W-1:0]   m_addr,
    output logic [DATA_W-1:0]   m_data,
    output logic [DATA_W/8-1:0] m_strb,
    output logic                m_last,
    output logic                m_we,
    output logic                error_4kb
);

    // Buffer word widths
    localparam int STRB_W   = DATA_W / 8;
    localparam int AW_WIDTH = ID_W + ADDR_W + LEN_W + SIZE_W + BURST_W;
    localparam int W_WIDTH  = DATA_W + STRB_W + 1;
    localparam int B_WIDTH  = ID_W + RESP_W;

    logic [AW_WIDTH-1:0] aw_word;
    logic [W_WIDTH-1:0]  w_word;
    logic                aw_full;
    logic                aw_empty;
    logic                w_full;
    logic                w_empty;
    logic                b_empty;

    aw_entry_if #(.ID_W(ID_W), .ADDR_W(ADDR_W)) aw_if ();
    w_entry_if  #(.DATA_W(DATA_W))              w_if ();
    b_push_if   #(.ID_W(ID_W))                  b_if ();

    // ----------------------------------------------------------------------
    // AXI handshakes
    // ----------------------------------------------------------------------
    assign aw_ready = !aw_full;
    assign w_ready  = !w_full;
    assign b_valid  = !b_empty;

    // Head entries unpacked for the controller
    assign {aw_if.id, aw_if.addr, aw_if.len, aw_if.size} = aw_word[AW_WIDTH-1:BURST_W];
    assign aw_if.burst = burst_t'(aw_word[BURST_W-1:0]);
    assign aw_if.avail = !aw_empty;
    assign {w_if.data, w_if.strb, w_if.last} = w_word;
    assign w_if.avail  = !w_empty;

    // ----------------------------------------------------------------------
    // Buffers
    // ----------------------------------------------------------------------
    sync_fifo #(.WIDTH(AW_WIDTH), .DEPTH(AW_DEPTH)) aw_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (aw_valid && aw_ready),
        .pop   (aw_if.pop),
        .din   ({aw_id, aw_addr, aw_len, aw_size, aw_burst}),
        .dout  (aw_word),
        .full  (aw_full),
        .empty (aw_empty)
    );

    sync_fifo #(.WIDTH(W_WIDTH), .DEPTH(W_DEPTH)) w_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (w_valid && w_ready),
        .pop   (w_if.pop),
        .din   ({w_data, w_strb, w_last}),
        .dout  (w_word),
        .full  (w_full),
        .empty (w_empty)
    );

    // Responses leave in the order the controller pushed them
    sync_fifo #(.WIDTH(B_WIDTH), .DEPTH(B_DEPTH)) b_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (b_if.push),
        .pop   (b_valid && b_ready),
        .din   ({b_if.id, b_if.resp}),
        .dout  ({b_id, b_resp}),
        .full  (b_if.full),
        .empty (b_empty)
    );

    wr_burst_ctrl #(
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .ID_W   (ID_W)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .grant     (grant),
        .aw        (aw_if),
        .w         (w_if),
        .b         (b_if),
        .m_id      (m_id),
        .m_len     (m_len),
        .m_size    (m_size),
        .m_burst   (m_burst),
        .m_addr    (m_addr),
        .m_data    (m_data),
        .m_strb    (m_strb),
        .m_last    (m_last),
        .m_we      (m_we),
        .error_4kb (error_4kb)
    );

endmodule

// File: axi_slv_wr_props.sv
// Bound into wr_burst_ctrl; checks only the buffer links and the BRESP stall
`timescale 1ns/1ps

module axi_slv_wr_props import slv_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   aw_pop,
    input logic   aw_avail,
    input logic   w_pop,
    input logic   w_avail,
    input logic   b_push,
    input logic   b_full,
    input phase_t phase,
    input logic   m_we
);

    // Head entries consumed only when present
    a_aw_pop: assert property (@(posedge clk) disable iff (!rst_n) aw_pop |-> aw_avail)
        else $error("address pop while the address buffer is empty");
    a_w_pop: assert property (@(posedge clk) disable iff (!rst_n) w_pop |-> w_avail)
        else $error("data pop while the data buffer is empty");

    // Response buffer never overrun
    a_b_push: assert property (@(posedge clk) disable iff (!rst_n) b_push |-> !b_full)
        else $error("response push while the response buffer is full");

    // No beats while waiting for response room
    a_bresp: assert property (@(posedge clk) disable iff (!rst_n) (phase == BRESP) |-> !m_we)
        else $error("beat issued in the response wait phase");

endmodule

bind wr_burst_ctrl axi_slv_wr_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_pop   (aw.pop),
    .aw_avail (aw.avail),
    .w_pop    (w.pop),
    .w_avail  (w.avail),
    .b_push   (b.push),
    .b_full   (b.full),
    .phase    (phase),
    .m_we     (m_we)
);

// File: burst_addr_gen.sv
// Beat address for FIXED and INCR (WRAP walks as INCR); a page crossing holds the address
`timescale 1ns/1ps

module burst_addr_gen import axi_pkg::*, slv_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              first,
    input  logic              beat,
    input  logic [ADDR_W-1:0] start_addr,
    input  logic [LEN_W-1:0]  len,
    input  logic [SIZE_W-1:0] size,
    input  burst_t            burst,
    output logic [ADDR_W-1:0] addr,
    output logic              last_beat,
    output logic              cross_4kb
);

    logic [ADDR_W-1:0] cur_addr;
    logic [LEN_W-1:0]  beat_cnt;
    logic [ADDR_W-1:0] align_mask;
    logic [ADDR_W-1:0] step;
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] cand_addr;
    logic [ADDR_W-1:0] next_addr;
    logic              leaves_page;

    // ----------------------------------------------------------------------
    // Current beat
    // ----------------------------------------------------------------------

    // First beat uses the raw start, which may be unaligned
    assign addr = first ? start_addr : cur_addr;

    // Beats seen so far against AWLEN
    assign last_beat = first ? (len == '0) : (beat_cnt == len);

    // ----------------------------------------------------------------------
    // Next address
    // ----------------------------------------------------------------------

    // Low address bits cleared up to the transfer size
    assign align_mask = {ADDR_W{1'b1}} << size;
    // Bytes per beat
    assign step = ADDR_W'(1) << size;

    // Only the first step aligns, later addresses are aligned already
    assign base_addr = first ? (start_addr & align_mask) : cur_addr;

    // FIXED repeats the start address unchanged on every beat
    assign cand_addr = (burst == FIXED) ? addr : base_addr + step;

    // Page of the candidate against the page of the start
    assign leaves_page = cand_addr[ADDR_W-1:PAGE_BIT] != start_addr[ADDR_W-1:PAGE_BIT];

    // Stay at the page edge instead of stepping out
    assign next_addr = leaves_page ? addr : cand_addr;

    // No following beat means no real crossing
    assign cross_4kb = leaves_page && !last_beat;

    // Advance once per issued beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_addr <= '0;
            beat_cnt <= '0;
        end else if (beat) begin
            cur_addr <= next_addr;
            beat_cnt <= first ? LEN_W'(1) : beat_cnt + 1'b1;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the AXI write slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f vlog.f --top-module tb_axi_slv_wr -o sim_tb_axi_slv_wr
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_tb_axi_slv_wr
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished cleanly"
exit 0

// File: slv_pkg.sv
// Slave-side constants; the page check needs an address wider than PAGE_BIT
package slv_pkg;

    // ----------------------------------------------------------------------
    // Address map
    // ----------------------------------------------------------------------

    // Lowest address bit above a 4 KB page
    localparam int PAGE_BIT = 12;

    // ----------------------------------------------------------------------
    // Burst phase of the write controller
    // ----------------------------------------------------------------------

    // FIRST issues the first beat, and single-beat bursts finish there
    // BURST issues the remaining beats one per cycle
    // BRESP waits for room in the response buffer
    // IDLE is only seen for one cycle after reset
    typedef enum logic [1:0] {
        FIRST = 2'b00,
        BURST = 2'b01,
        BRESP = 2'b10,
        IDLE  = 2'b11
    } phase_t;

endpackage

// File: sync_fifo.sv
// Show-ahead FIFO on one clock; push when full and pop when empty are dropped
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Qualified requests
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    // Head word straight from storage, no read latency
    assign dout = mem[rd_ptr];

    // ----------------------------------------------------------------------
    // Pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at DEPTH, so any depth works
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

// File: tb_axi_slv_wr.sv
// DATA_W fixed at 32; only FIXED and INCR bursts are driven, WRAP is never exercised
`timescale 1ns/1ps

module tb_axi_slv_wr import axi_pkg::*, slv_pkg::*; ();

    localparam int DATA_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int ID_W     = 4;
    localparam int AW_DEPTH = 4;
    localparam int W_DEPTH  = 16;
    localparam int B_DEPTH  = 4;
    localparam int STRB_W   = DATA_W / 8;
    localparam int N_TXN    = 80;
    localparam logic [31:0] SEED = 32'h730fe0e4;
    // Four bytes per beat on a 32-bit bus, larger sizes get SLVERR
    localparam logic [SIZE_W-1:0] MAX_SIZE = 3'd2;

    logic clk, rst_n, grant;
    logic [ID_W-1:0] aw_id, b_id, m_id;
    logic [ADDR_W-1:0] aw_addr, m_addr;
    logic [LEN_W-1:0] aw_len, m_len;
    logic [SIZE_W-1:0] aw_size, m_size;
    logic [BURST_W-1:0] aw_burst, m_burst;
    logic aw_valid, aw_ready, w_last, w_valid, w_ready;
    logic [DATA_W-1:0] w_data, m_data;
    logic [STRB_W-1:0] w_strb, m_strb;
    logic [RESP_W-1:0] b_resp;
    logic b_valid, b_ready, m_last, m_we, error_4kb;

    // Transaction list, built once before reset
    logic [ID_W-1:0] t_id [N_TXN];
    logic [ADDR_W-1:0] t_addr [N_TXN];
    logic [LEN_W-1:0] t_len [N_TXN];
    logic [SIZE_W-1:0] t_size [N_TXN];
    logic [BURST_W-1:0] t_burst [N_TXN];

    // Reference model: accepted address entries, data beats, responses
    logic [ID_W-1:0] q_id [$];
    logic [ADDR_W-1:0] q_addr [$];
    logic [LEN_W-1:0] q_len [$];
    logic [SIZE_W-1:0] q_size [$];
    logic [BURST_W-1:0] q_burst [$];
    logic [DATA_W-1:0] d_data [$];
    logic [STRB_W-1:0] d_strb [$];
    logic d_last [$];
    logic [ID_W-1:0] exp_id [$];
    logic [RESP_W-1:0] exp_resp [$];

    logic [ADDR_W-1:0] exp_addr;
    int beat_idx, bursts_done, resp_cnt, aw_held, w_held;
    int cyc, timeout_limit, aw_next, w_txn, w_beat;
    bit go, aw_fire, w_fire;

    axi_slv_wr #(
        .DATA_W (DATA_W), .ADDR_W (ADDR_W), .ID_W (ID_W),
        .AW_DEPTH (AW_DEPTH), .W_DEPTH (W_DEPTH), .B_DEPTH (B_DEPTH)
    ) dut (
        .clk (clk), .rst_n (rst_n),
        .aw_id (aw_id), .aw_addr (aw_addr), .aw_len (aw_len), .aw_size (aw_size),
        .aw_burst (aw_burst), .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w_data (w_data), .w_strb (w_strb), .w_last (w_last),
        .w_valid (w_valid), .w_ready (w_ready),
        .b_id (b_id), .b_resp (b_resp), .b_valid (b_valid), .b_ready (b_ready),
        .grant (grant), .m_id (m_id), .m_len (m_len), .m_size (m_size),
        .m_burst (m_burst), .m_addr (m_addr), .m_data (m_data), .m_strb (m_strb),
        .m_last (m_last), .m_we (m_we), .error_4kb (error_4kb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Error reporting
    // ----------------------------------------------------------------------
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic value_error(input string msg);
        stop_with_error($sformatf("Fail at %0t ns: %s", $time, msg));
    endtask

    // ----------------------------------------------------------------------
    // Stimulus generation
    // ----------------------------------------------------------------------
    task automatic build_txn_list(output int total_beats);
        int kind;
        total_beats = 0;
        for (int i = 0; i < N_TXN; i++) begin
            // First few are plain single-beat word writes
            kind = (i < 8) ? 8 : int'($urandom % 8);
            t_id[i]    = ID_W'($urandom);
            t_addr[i]  = ADDR_W'($urandom);
            t_len[i]   = LEN_W'($urandom % 16);
            t_size[i]  = SIZE_W'($urandom % 3);
            t_burst[i] = INCR;
            case (kind)
                8: begin
                    t_addr[i] = t_addr[i] & ~ADDR_W'(3);
                    t_len[i]  = '0;
                    t_size[i] = SIZE_W'(2);
                end
                0: t_len[i] = '0;
                1: begin
                    t_burst[i] = FIXED;
                    t_len[i]   = LEN_W'($urandom % 8);
                end
                2: begin
                    // Starts in the last 32 bytes of a page, always runs past it
                    t_addr[i] = t_addr[i] | ADDR_W'(12'hfe0);
                    t_len[i]  = LEN_W'(8 + $urandom % 8);
                    t_size[i] = SIZE_W'(2);
                end
                3: begin
                    t_size[i] = SIZE_W'(3 + $urandom % 2);
                    t_len[i]  = LEN_W'($urandom % 4);
                end
                default: ;
            endcase
            total_beats += int'(t_len[i]) + 1;
        end
    endtask

    // AW channel, valid held until accepted
    always @(posedge clk) begin
        if (go && (!aw_valid || aw_fire)) begin
            if (aw_next < N_TXN && ($urandom % 4) != 0) begin
                aw_id    <= t_id[aw_next];
                aw_addr  <= t_addr[aw_next];
                aw_len   <= t_len[aw_next];
                aw_size  <= t_size[aw_next];
                aw_burst <= t_burst[aw_next];
                aw_valid <= 1'b1;
                aw_next++;
            end else begin
                aw_valid <= 1'b0;
            end
        end
    end

    // W channel, beats in transaction order
    always @(posedge clk) begin
        if (go && (!w_valid || w_fire)) begin
            if (w_txn < N_TXN && ($urandom % 5) != 0) begin
                w_data  <= DATA_W'($urandom);
                w_strb  <= STRB_W'($urandom);
                w_last  <= (w_beat == int'(t_len[w_txn]));
                w_valid <= 1'b1;
                if (w_beat == int'(t_len[w_txn])) begin
                    w_beat = 0;
                    w_txn++;
                end else begin
                    w_beat++;
                end
            end else begin
                w_valid <= 1'b0;
            end
        end
    end

    // Grant and b_ready: free at first, then random, with a long b_ready stall
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (go && cyc >= timeout_limit) begin
            stop_with_error($sformatf("Timeout after %0d cycles with %0d of %0d responses",
                                      cyc, resp_cnt, N_TXN));
        end
        if (go) begin
            if (cyc < 200) begin
                grant   <= 1'b1;
                b_ready <= 1'b1;
            end else begin
                grant   <= ($urandom % 4) != 0;
                b_ready <= (cyc >= 300 && cyc < 600) ? 1'b0 : ($urandom % 3) != 0;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Model and checks, sampled at the falling edge
    // ----------------------------------------------------------------------
    task automatic check_beat();
        logic [ADDR_W-1:0] start;
        logic [ADDR_W-1:0] step;
        logic [ADDR_W-1:0] cand;
        logic leave;
        logic last;
        if (q_id.size() == 0 || d_data.size() == 0) begin
            stop_with_error("A beat was issued with no address entry or data beat held");
        end
        start = q_addr[0];
        if (beat_idx == 0) begin
            exp_addr = start;
        end
        last = (beat_idx == int'(q_len[0]));
        step = ADDR_W'(1) << q_size[0];
        // Align only on the first step, FIXED never moves
        if (q_burst[0] == FIXED) begin
            cand = exp_addr;
        end else if (beat_idx == 0) begin
            cand = (start & ~(step - ADDR_W'(1))) + step;
        end else begin
            cand = exp_addr + step;
        end
        leave = cand[ADDR_W-1:PAGE_BIT] != start[ADDR_W-1:PAGE_BIT];
        assert (m_addr == exp_addr)
            else value_error($sformatf("beat %0d addr %h, expected %h",
                                       beat_idx, m_addr, exp_addr));
        assert (m_id == q_id[0] && m_len == q_len[0] && m_size == q_size[0] &&
                m_burst == q_burst[0])
            else value_error($sformatf("beat fields id %h len %0d, expected id %h len %0d",
                                       m_id, m_len, q_id[0], q_len[0]));
        assert (m_data == d_data[0] && m_strb == d_strb[0])
            else value_error($sformatf("data %h strb %h, expected %h strb %h",
                                       m_data, m_strb, d_data[0], d_strb[0]));
        assert (m_last == last && m_last == d_last[0])
            else value_error($sformatf("m_last %b on beat %0d of len %0d",
                                       m_last, beat_idx, q_len[0]));
        assert (error_4kb == (leave && !last))
            else value_error($sformatf("error_4kb %b at addr %h", error_4kb, m_addr));
        // Held at the page edge once the next step would leave it
        exp_addr = leave ? exp_addr : cand;
        void'(d_data.pop_front());
        void'(d_strb.pop_front());
        void'(d_last.pop_front());
        w_held--;
        if (beat_idx == 0) begin
            aw_held--;
        end
        if (last) begin
            void'(q_id.pop_front());
            void'(q_addr.pop_front());
            void'(q_len.pop_front());
            void'(q_size.pop_front());
            void'(q_burst.pop_front());
            beat_idx = 0;
            bursts_done++;
        end else begin
            beat_idx++;
        end
    endtask

    always @(negedge clk) begin
        aw_fire = aw_valid && aw_ready;
        w_fire  = w_valid && w_ready;
        if (go) begin
            // Ready drops exactly when the model says the buffer is full
            assert (aw_ready == (aw_held < AW_DEPTH))
                else value_error($sformatf("aw_ready %b with %0d entries held",
                                           aw_ready, aw_held));
            assert (w_ready == (w_held < W_DEPTH))
                else value_error($sformatf("w_ready %b with %0d beats held", w_ready, w_held));
            if (b_valid && b_ready) begin
                if (exp_id.size() == 0 || resp_cnt >= bursts_done) begin
                    stop_with_error("A response came back before its burst finished");
                end
                assert (b_id == exp_id[0] && b_resp == exp_resp[0])
                    else value_error($sformatf("response id %h resp %b, expected id %h resp %b",
                                               b_id, b_resp, exp_id[0], exp_resp[0]));
                void'(exp_id.pop_front());
                void'(exp_resp.pop_front());
                resp_cnt++;
            end
            if (m_we) begin
                // A beat only issues while the user side grants it
                assert (grant)
                    else stop_with_error("A beat was issued while grant was low");
                check_beat();
            end else begin
                assert (m_strb == '0 && !m_last && !error_4kb)
                    else value_error("user strobe, last or error_4kb active without m_we");
            end
            if (aw_fire) begin
                q_id.push_back(aw_id);
                q_addr.push_back(aw_addr);
                q_len.push_back(aw_len);
                q_size.push_back(aw_size);
                q_burst.push_back(aw_burst);
                exp_id.push_back(aw_id);
                exp_resp.push_back((aw_size > MAX_SIZE) ? RESP_SLVERR : RESP_OKAY);
                aw_held++;
            end
            if (w_fire) begin
                d_data.push_back(w_data);
                d_strb.push_back(w_strb);
                d_last.push_back(w_last);
                w_held++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Run control
    // ----------------------------------------------------------------------
    initial begin
        int total_beats;
        rst_n    <= 1'b0;
        grant    <= 1'b0;
        b_ready  <= 1'b0;
        aw_valid <= 1'b0;
        aw_id    <= '0;
        aw_addr  <= '0;
        aw_len   <= '0;
        aw_size  <= '0;
        aw_burst <= '0;
        w_valid  <= 1'b0;
        w_data   <= '0;
        w_strb   <= '0;
        w_last   <= 1'b0;
        void'($urandom(SEED));
        build_txn_list(total_beats);
        timeout_limit = total_beats * 8 + 2000;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!m_we && !b_valid && !error_4kb && aw_ready && w_ready)
            else value_error("outputs not at their reset values");
        go = 1'b1;
        while (resp_cnt < N_TXN) @(posedge clk);
        @(negedge clk);
        if (q_id.size() != 0 || d_data.size() != 0 || exp_id.size() != 0 || b_valid) begin
            stop_with_error("Beats or responses left over after the last expected response");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: vlog.f
axi_pkg.sv
slv_pkg.sv
wr_ifs.sv
sync_fifo.sv
burst_addr_gen.sv
wr_burst_ctrl.sv
axi_slv_wr.sv
axi_slv_wr_props.sv
tb_axi_slv_wr.sv

// File: wr_burst_ctrl.sv
// In-order burst walker; one beat per cycle while data is buffered and grant is high
`timescale 1ns/1ps

module wr_burst_ctrl import axi_pkg::*, slv_pkg::*; #(
    parameter int DATA_W = 32,
    parameter int ADDR_W = 32,
    parameter int ID_W   = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                grant,
    aw_entry_if.ctrl            aw,
    w_entry_if.ctrl             w,
    b_push_if.ctrl              b,
    output logic [ID_W-1:0]     m_id,
    output logic [LEN_W-1:0]    m_len,
    output logic [SIZE_W-1:0]   m_size,
    output burst_t              m_burst,
    output logic [ADDR_W-1:0]   m_addr,
    output logic [DATA_W-1:0]   m_data,
    output logic [DATA_W/8-1:0] m_strb,
    output logic                m_last,
    output logic                m_we,
    output logic                error_4kb
);

    // Widest legal AWSIZE for this bus
    localparam logic [SIZE_W-1:0] MAX_SIZE = SIZE_W'($clog2(DATA_W / 8));

    phase_t            phase;
    phase_t            phase_nxt;
    logic [ID_W-1:0]   lat_id;
    logic [ADDR_W-1:0] lat_addr;
    logic [LEN_W-1:0]  lat_len;
    logic [SIZE_W-1:0] lat_size;
    burst_t            lat_burst;
    logic              in_first;
    logic              first_go;
    logic              burst_go;
    logic              last_go;
    logic              last_beat;
    logic              cross_4kb;
    logic [ADDR_W-1:0] start_addr;

    // ----------------------------------------------------------------------
    // Beat issue
    // ----------------------------------------------------------------------
    assign in_first = (phase == FIRST);

    // First beat needs the address entry and a data beat together
    assign first_go = in_first && aw.avail && w.avail && grant;
    assign burst_go = (phase == BURST) && w.avail && grant;

    assign aw.pop = first_go;
    assign w.pop  = first_go || burst_go;
    assign m_we   = w.pop;

    // Final beat of the burst by the AWLEN count
    assign last_go = m_we && last_beat;

    // Live head in FIRST, latched entry afterwards
    assign m_id       = in_first ? aw.id    : lat_id;
    assign m_len      = in_first ? aw.len   : lat_len;
    assign m_size     = in_first ? aw.size  : lat_size;
    assign m_burst    = in_first ? aw.burst : lat_burst;
    assign start_addr = in_first ? aw.addr  : lat_addr;

    assign m_data    = w.data;
    assign m_strb    = m_we ? w.strb : '0;
    assign m_last    = m_we ? w.last : 1'b0;
    assign error_4kb = m_we && cross_4kb;

    // ----------------------------------------------------------------------
    // Response
    // ----------------------------------------------------------------------
    assign b.id   = m_id;
    // Beat wider than the bus
    assign b.resp = (m_size > MAX_SIZE) ? RESP_SLVERR : RESP_OKAY;
    assign b.push = !b.full && (last_go || phase == BRESP);

    // ----------------------------------------------------------------------
    // Phase machine
    // ----------------------------------------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            FIRST: begin
                if (last_go) begin
                    phase_nxt = b.full ? BRESP : FIRST;
                end else if (first_go) begin
                    phase_nxt = BURST;
                end
            end
            BURST: begin
                if (last_go) begin
                    phase_nxt = b.full ? BRESP : FIRST;
                end
            end
            BRESP:   phase_nxt = b.full ? BRESP : FIRST;
            IDLE:    phase_nxt = FIRST;
            default: phase_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

    // Hold the entry for the rest of the burst
    always_ff @(posedge clk) begin
        if (aw.pop) begin
            lat_id    <= aw.id;
            lat_addr  <= aw.addr;
            lat_len   <= aw.len;
            lat_size  <= aw.size;
            lat_burst <= aw.burst;
        end
    end

    burst_addr_gen #(
        .ADDR_W (ADDR_W)
    ) u_addr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .first      (in_first),
        .beat       (m_we),
        .start_addr (start_addr),
        .len        (m_len),
        .size       (m_size),
        .burst      (m_burst),
        .addr       (m_addr),
        .last_beat  (last_beat),
        .cross_4kb  (cross_4kb)
    );

endmodule

// File: wr_ifs.sv
// Internal buffer links; pop is legal only with avail high, push only with full low
`timescale 1ns/1ps

// Head entry of the address buffer
interface aw_entry_if import axi_pkg::*; #(
    parameter int ID_W   = 4,
    parameter int ADDR_W = 32
);
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
    logic [SIZE_W-1:0] size;
    burst_t            burst;
    // Buffer not empty
    logic              avail;
    // One-cycle consume of the head entry
    logic              pop;

    modport fifo (output id, addr, len, size, burst, avail, input pop);
    modport ctrl (input id, addr, len, size, burst, avail, output pop);
endinterface

// Head beat of the data buffer
interface w_entry_if #(
    parameter int DATA_W = 32
);
    logic [DATA_W-1:0]   data;
    logic [DATA_W/8-1:0] strb;
    logic                last;
    logic                avail;
    logic                pop;

    modport fifo (output data, strb, last, avail, input pop);
    modport ctrl (input data, strb, last, avail, output pop);
endinterface

// Write side of the response buffer
interface b_push_if import axi_pkg::*; #(
    parameter int ID_W = 4
);
    logic [ID_W-1:0]   id;
    logic [RESP_W-1:0] resp;
    logic              push;
    // Response buffer has no room
    logic              full;

    modport fifo (input id, resp, push, output full);
    modport ctrl (output id, resp, push, input full);
endinterface
